//--- common/ex_config.svh
`ifndef EX_CONFIG_SVH
`define EX_CONFIG_SVH

//////////////////////////////
// Execute stage widths
//////////////////////////////

// Integer data path width
`define EX_XLEN 32

// Register file address width
// Six bits leave room for a second register bank
`define EX_RF_AW 6

`endif

//--- common/ex_pkg.sv
`include "ex_config.svh"

package ex_pkg;

  //////////////////////////////
  // Opcodes and states
  //////////////////////////////

  // ALU opcodes
  // Arithmetic and logic first, branch compares in the upper half
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_AND,
    ALU_OR,
    ALU_XOR,
    ALU_SLL,
    ALU_SRL,
    ALU_SRA,
    ALU_SLT,
    ALU_SLTU,
    ALU_EQ,
    ALU_NE,
    ALU_LT,
    ALU_GE,
    ALU_LTU,
    ALU_GEU
  } alu_op_e;

  // Multiplier opcodes
  typedef enum logic [1:0] {
    MUL_MUL,
    MUL_MULH,
    MUL_MULHSU,
    MUL_MULHU
  } mul_op_e;

  // High-word multiply sequence
  typedef enum logic [1:0] {
    MS_IDLE,
    MS_PARTIAL,
    MS_FINISH
  } mul_state_e;

  // Forwarding data source
  typedef enum logic [1:0] {
    SRC_NONE,
    SRC_ALU,
    SRC_MUL,
    SRC_CSR
  } ex_src_e;

  //////////////////////////////
  // Commands and write ports
  //////////////////////////////

  // operand_c carries the jump target
  typedef struct packed {
    logic                enable;
    alu_op_e             op;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [`EX_XLEN-1:0] operand_c;
  } alu_cmd_t;

  typedef struct packed {
    logic                enable;
    mul_op_e             op;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
  } mul_cmd_t;

  // Destination register from decode
  typedef struct packed {
    logic                 we;
    logic [`EX_RF_AW-1:0] addr;
  } rf_dest_t;

  // One register file write port
  typedef struct packed {
    logic                 we;
    logic [`EX_RF_AW-1:0] addr;
    logic [`EX_XLEN-1:0]  data;
  } rf_wr_t;

endpackage

//--- alu/ex_alu.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_alu (
  input  ex_pkg::alu_cmd_t    cmd_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  logic [`EX_XLEN-1:0] op_a;
  logic [`EX_XLEN-1:0] op_b;
  logic                do_sub;
  logic [`EX_XLEN-1:0] adder_b;
  logic [`EX_XLEN:0]   adder_sum;
  logic                is_eq;
  logic                is_ltu;
  logic                is_lt;
  logic [4:0]          shamt;

  assign op_a  = cmd_i.operand_a;
  assign op_b  = cmd_i.operand_b;
  assign shamt = op_b[4:0];

  //////////////////////////////
  // Shared adder
  //////////////////////////////

  // Everything except add runs through the subtractor
  assign do_sub  = (cmd_i.op != ex_pkg::ALU_ADD);
  assign adder_b = do_sub ? ~op_b : op_b;

  // Carry out of a - b means no borrow
  assign adder_sum = {1'b0, op_a} + {1'b0, adder_b} + {{`EX_XLEN{1'b0}}, do_sub};

  //////////////////////////////
  // Comparisons
  //////////////////////////////

  assign is_eq  = (op_a == op_b);
  assign is_ltu = ~adder_sum[`EX_XLEN];

  // Differing signs decide directly, otherwise the difference sign does
  assign is_lt = (op_a[`EX_XLEN-1] ^ op_b[`EX_XLEN-1]) ? op_a[`EX_XLEN-1]
                                                       : adder_sum[`EX_XLEN-1];

  always_comb begin
    case (cmd_i.op)
      ex_pkg::ALU_EQ:  cmp_result_o = is_eq;
      ex_pkg::ALU_NE:  cmp_result_o = ~is_eq;
      ex_pkg::ALU_LT:  cmp_result_o = is_lt;
      ex_pkg::ALU_GE:  cmp_result_o = ~is_lt;
      ex_pkg::ALU_LTU: cmp_result_o = is_ltu;
      ex_pkg::ALU_GEU: cmp_result_o = ~is_ltu;
      default:         cmp_result_o = 1'b0;
    endcase
  end

  //////////////////////////////
  // Result mux
  //////////////////////////////

  // Branch compares give a zero result
  always_comb begin
    case (cmd_i.op)
      ex_pkg::ALU_ADD,
      ex_pkg::ALU_SUB:  result_o = adder_sum[`EX_XLEN-1:0];
      ex_pkg::ALU_AND:  result_o = op_a & op_b;
      ex_pkg::ALU_OR:   result_o = op_a | op_b;
      ex_pkg::ALU_XOR:  result_o = op_a ^ op_b;
      ex_pkg::ALU_SLL:  result_o = op_a << shamt;
      ex_pkg::ALU_SRL:  result_o = op_a >> shamt;
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(op_a) >>> shamt);
      ex_pkg::ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, is_lt};
      ex_pkg::ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, is_ltu};
      default:          result_o = '0;
    endcase
  end

endmodule

//--- mult/ex_mult.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_mult (
  input  logic                clk,
  input  logic                rst_n,
  input  ex_pkg::mul_cmd_t    cmd_i,
  input  logic                ex_ready_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                ready_o,
  output logic                multicycle_o
);

  ex_pkg::mul_state_e state_q;
  ex_pkg::mul_state_e state_d;

  logic                 start_high;
  logic                 sign_a;
  logic                 sign_b;
  logic [`EX_XLEN-1:0]  prod_lo;

  // Operands widened by one bit so one signed multiply covers every variant
  logic signed [32:0]   op_a_ext;
  logic signed [32:0]   op_b_ext;
  logic signed [16:0]   b_lo;
  logic signed [16:0]   b_hi;
  logic signed [49:0]   pp_lo;
  logic signed [49:0]   pp_hi;
  logic signed [65:0]   pp_hi_sh;
  logic signed [65:0]   acc_q;

  //////////////////////////////
  // Operand preparation
  //////////////////////////////

  // mul only needs the low word, available at once
  assign prod_lo = cmd_i.operand_a * cmd_i.operand_b;

  assign start_high = cmd_i.enable & (cmd_i.op != ex_pkg::MUL_MUL);

  // mulh is signed x signed, mulhsu signed x unsigned, mulhu unsigned
  assign sign_a = (cmd_i.op == ex_pkg::MUL_MULH) | (cmd_i.op == ex_pkg::MUL_MULHSU);
  assign sign_b = (cmd_i.op == ex_pkg::MUL_MULH);

  assign op_a_ext = {sign_a & cmd_i.operand_a[`EX_XLEN-1], cmd_i.operand_a};
  assign op_b_ext = {sign_b & cmd_i.operand_b[`EX_XLEN-1], cmd_i.operand_b};

  // Low half of b is unsigned, upper half keeps the sign
  assign b_lo = {1'b0, op_b_ext[15:0]};
  assign b_hi = op_b_ext[32:16];

  assign pp_lo    = op_a_ext * b_lo;
  assign pp_hi    = op_a_ext * b_hi;
  assign pp_hi_sh = 66'(pp_hi) <<< 16;

  //////////////////////////////
  // Sequence FSM
  //////////////////////////////

  always_comb begin
    state_d = state_q;
    case (state_q)
      ex_pkg::MS_IDLE: begin
        if (start_high) begin
          state_d = ex_pkg::MS_PARTIAL;
        end
      end
      ex_pkg::MS_PARTIAL: begin
        state_d = ex_pkg::MS_FINISH;
      end
      ex_pkg::MS_FINISH: begin
        // Hold the upper word until the stage moves on
        if (ex_ready_i) begin
          state_d = ex_pkg::MS_IDLE;
        end
      end
      default: begin
        state_d = ex_pkg::MS_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ex_pkg::MS_IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Low partial product in idle, high one added in partial
  always_ff @(posedge clk) begin
    if ((state_q == ex_pkg::MS_IDLE) && start_high) begin
      acc_q <= pp_lo;
    end else if (state_q == ex_pkg::MS_PARTIAL) begin
      acc_q <= acc_q + pp_hi_sh;
    end
  end

  //////////////////////////////
  // Outputs
  //////////////////////////////

  assign multicycle_o = (state_q == ex_pkg::MS_FINISH);

  // Ready in idle unless a high product is starting
  assign ready_o = (state_q == ex_pkg::MS_FINISH) |
                   ((state_q == ex_pkg::MS_IDLE) & ~start_high);

  assign result_o = multicycle_o ? acc_q[63:32] : prod_lo;

endmodule

//--- design/ex_issue_ctrl.sv
`timescale 1ns/1ps

module ex_issue_ctrl (
  // Unit enables of the issued instruction
  input  logic            alu_en_i,
  input  logic            mul_en_i,
  input  logic            csr_access_i,
  input  logic            lsu_en_i,

  // Readiness of the units and of writeback
  input  logic            mult_ready_i,
  input  logic            lsu_ready_ex_i,
  input  logic            wb_ready_i,
  input  logic            branch_in_ex_i,

  output ex_pkg::ex_src_e src_sel_o,
  output logic            ex_ready_o,
  output logic            ex_valid_o
);

  logic units_ready;
  logic any_en;

  //////////////////////////////
  // Forwarding source
  //////////////////////////////

  // CSR wins over the multiplier, the multiplier over the ALU
  always_comb begin
    if (csr_access_i) begin
      src_sel_o = ex_pkg::SRC_CSR;
    end else if (mul_en_i) begin
      src_sel_o = ex_pkg::SRC_MUL;
    end else if (alu_en_i) begin
      src_sel_o = ex_pkg::SRC_ALU;
    end else begin
      src_sel_o = ex_pkg::SRC_NONE;
    end
  end

  //////////////////////////////
  // Stage ready and valid
  //////////////////////////////

  // Everything downstream can take a result this cycle
  assign units_ready = mult_ready_i & lsu_ready_ex_i & wb_ready_i;

  // Some unit has work for writeback
  assign any_en = alu_en_i | mul_en_i | csr_access_i | lsu_en_i;

  // A branch resolves here and never needs writeback,
  // so it releases the stage even under back-pressure
  assign ex_ready_o = units_ready | branch_in_ex_i;

  // Valid goes right and ready goes left, valid ignores the branch
  assign ex_valid_o = any_en & units_ready;

endmodule

//--- design/ex_write_ports.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_write_ports (
  input  logic                clk,
  input  logic                rst_n,

  // Forwarding data sources
  input  ex_pkg::ex_src_e     src_sel_i,
  input  logic [`EX_XLEN-1:0] alu_result_i,
  input  logic [`EX_XLEN-1:0] mul_result_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,

  // Destinations from decode
  input  ex_pkg::rf_dest_t    alu_dest_i,
  input  ex_pkg::rf_dest_t    wb_dest_i,

  // Load data and stage control
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,
  input  logic                lsu_err_i,
  input  logic                ex_valid_i,
  input  logic                wb_ready_i,

  output ex_pkg::rf_wr_t      fw_wr_o,
  output ex_pkg::rf_wr_t      wb_wr_o
);

  logic                 wb_we_q;
  logic [`EX_RF_AW-1:0] wb_addr_q;
  logic                 wb_we_next;
  logic [`EX_XLEN-1:0]  fw_data;

  //////////////////////////////
  // Forwarding port
  //////////////////////////////

  always_comb begin
    case (src_sel_i)
      ex_pkg::SRC_ALU: fw_data = alu_result_i;
      ex_pkg::SRC_MUL: fw_data = mul_result_i;
      ex_pkg::SRC_CSR: fw_data = csr_rdata_i;
      default:         fw_data = '0;
    endcase
  end

  // Same cycle write, enable straight from decode
  assign fw_wr_o.we   = alu_dest_i.we;
  assign fw_wr_o.addr = alu_dest_i.addr;
  assign fw_wr_o.data = fw_data;

  //////////////////////////////
  // EX/WB pipeline register
  //////////////////////////////

  // A faulting load never reaches the register file
  assign wb_we_next = wb_dest_i.we & ~lsu_err_i;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_we_q <= 1'b0;
    end else if (ex_valid_i) begin
      wb_we_q <= wb_we_next;
    end else if (wb_ready_i) begin
      // Writeback drained with nothing new behind it
      wb_we_q <= 1'b0;
    end
  end

  // Address only moves with a real write
  always_ff @(posedge clk) begin
    if (ex_valid_i && wb_we_next) begin
      wb_addr_q <= wb_dest_i.addr;
    end
  end

  // Load data arrives during writeback, so it is not registered here
  assign wb_wr_o.we   = wb_we_q;
  assign wb_wr_o.addr = wb_addr_q;
  assign wb_wr_o.data = lsu_rdata_i;

endmodule

//--- design/ex_stage_top.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_top (
  input  logic                clk,
  input  logic                rst_n,

  // Issued instruction
  input  ex_pkg::alu_cmd_t    alu_cmd_i,
  input  ex_pkg::mul_cmd_t    mul_cmd_i,
  input  logic                csr_access_i,
  input  logic [`EX_XLEN-1:0] csr_rdata_i,

  // Load/store unit
  input  logic                lsu_en_i,
  input  logic [`EX_XLEN-1:0] lsu_rdata_i,
  input  logic                lsu_ready_ex_i,
  input  logic                lsu_err_i,

  // Decode side control
  input  logic                branch_in_ex_i,
  input  ex_pkg::rf_dest_t    alu_dest_i,
  input  ex_pkg::rf_dest_t    wb_dest_i,
  input  logic                wb_ready_i,

  // Register file ports
  output ex_pkg::rf_wr_t      fw_wr_o,
  output ex_pkg::rf_wr_t      wb_wr_o,

  // Towards fetch
  output logic [`EX_XLEN-1:0] jump_target_o,
  output logic                branch_decision_o,

  output logic                mult_multicycle_o,
  output logic                ex_ready_o,
  output logic                ex_valid_o
);

  ex_pkg::ex_src_e     src_sel;
  logic [`EX_XLEN-1:0] alu_result;
  logic [`EX_XLEN-1:0] mul_result;
  logic                mult_ready;

  // Jump target comes straight from decode
  assign jump_target_o = alu_cmd_i.operand_c;

  //////////////////////////////
  // Issue control
  //////////////////////////////

  ex_issue_ctrl i_issue_ctrl (
    .alu_en_i       (alu_cmd_i.enable),
    .mul_en_i       (mul_cmd_i.enable),
    .csr_access_i   (csr_access_i),
    .lsu_en_i       (lsu_en_i),
    .mult_ready_i   (mult_ready),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .wb_ready_i     (wb_ready_i),
    .branch_in_ex_i (branch_in_ex_i),
    .src_sel_o      (src_sel),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  //////////////////////////////
  // Processing units
  //////////////////////////////

  ex_alu i_alu (
    .cmd_i        (alu_cmd_i),
    .result_o     (alu_result),
    .cmp_result_o (branch_decision_o)
  );

  ex_mult i_mult (
    .clk          (clk),
    .rst_n        (rst_n),
    .cmd_i        (mul_cmd_i),
    .ex_ready_i   (ex_ready_o),
    .result_o     (mul_result),
    .ready_o      (mult_ready),
    .multicycle_o (mult_multicycle_o)
  );

  //////////////////////////////
  // Write ports
  //////////////////////////////

  ex_write_ports i_write_ports (
    .clk          (clk),
    .rst_n        (rst_n),
    .src_sel_i    (src_sel),
    .alu_result_i (alu_result),
    .mul_result_i (mul_result),
    .csr_rdata_i  (csr_rdata_i),
    .alu_dest_i   (alu_dest_i),
    .wb_dest_i    (wb_dest_i),
    .lsu_rdata_i  (lsu_rdata_i),
    .lsu_err_i    (lsu_err_i),
    .ex_valid_i   (ex_valid_o),
    .wb_ready_i   (wb_ready_i),
    .fw_wr_o      (fw_wr_o),
    .wb_wr_o      (wb_wr_o)
  );

endmodule

//--- bench/ex_stage_props.sv
`timescale 1ns/1ps

module ex_stage_props (
  input logic               clk,
  input logic               rst_n,
  input logic               ex_valid_o,
  input logic               ex_ready_o,
  input logic               wb_ready_i,
  input logic               branch_in_ex_i,
  input ex_pkg::rf_wr_t     wb_wr_o,
  input ex_pkg::mul_state_e mul_state
);

  // Read by the testbench at the end of the run
  int unsigned assert_fails = 0;

  // Valid never goes out while writeback is stalled
  valid_needs_wb: assert property (@(posedge clk) disable iff (!rst_n)
    ex_valid_o |-> wb_ready_i)
    else begin
      assert_fails++;
      $error("ex_valid_o high while wb_ready_i is low");
    end

  // Mid sequence the stage only moves for a branch
  mult_busy_stalls: assert property (@(posedge clk) disable iff (!rst_n)
    (mul_state != ex_pkg::MS_IDLE && mul_state != ex_pkg::MS_FINISH)
      |-> (!ex_ready_o || branch_in_ex_i))
    else begin
      assert_fails++;
      $error("ex_ready_o high while the multiplier is busy");
    end

  wb_clear_after_reset: assert property (@(posedge clk) $rose(rst_n) |-> !wb_wr_o.we)
    else begin
      assert_fails++;
      $error("wb_wr_o.we set in the first cycle after reset");
    end

endmodule

bind ex_stage_top ex_stage_props i_ex_stage_props (
  .clk            (clk),
  .rst_n          (rst_n),
  .ex_valid_o     (ex_valid_o),
  .ex_ready_o     (ex_ready_o),
  .wb_ready_i     (wb_ready_i),
  .branch_in_ex_i (branch_in_ex_i),
  .wb_wr_o        (wb_wr_o),
  .mul_state      (i_mult.state_q)
);

//--- bench/ex_stage_tb.sv
`timescale 1ns/1ps
`include "ex_config.svh"

module ex_stage_tb;

  localparam int CLK_PERIOD   = 10;
  localparam int RESET_CYCLES = 16;
  localparam int NUM_TESTS    = 6;
  localparam int STEP_CYCLES  = 40;
  localparam int TIMEOUT_NS   = (RESET_CYCLES + STEP_CYCLES * NUM_TESTS) * CLK_PERIOD;

  logic                clk;
  logic                rst_n;
  ex_pkg::alu_cmd_t    alu_cmd;
  ex_pkg::mul_cmd_t    mul_cmd;
  logic                csr_access;
  logic [`EX_XLEN-1:0] csr_rdata;
  logic                lsu_en;
  logic [`EX_XLEN-1:0] lsu_rdata;
  logic                lsu_ready_ex;
  logic                lsu_err;
  logic                branch_in_ex;
  ex_pkg::rf_dest_t    alu_dest;
  ex_pkg::rf_dest_t    wb_dest;
  logic                wb_ready;
  ex_pkg::rf_wr_t      fw_wr;
  ex_pkg::rf_wr_t      wb_wr;
  logic [`EX_XLEN-1:0] jump_target;
  logic                branch_decision;
  logic                mult_multicycle;
  logic                ex_ready;
  logic                ex_valid;

  integer seed;

  ex_stage_top i_ex_stage_top (
    .clk               (clk),
    .rst_n             (rst_n),
    .alu_cmd_i         (alu_cmd),
    .mul_cmd_i         (mul_cmd),
    .csr_access_i      (csr_access),
    .csr_rdata_i       (csr_rdata),
    .lsu_en_i          (lsu_en),
    .lsu_rdata_i       (lsu_rdata),
    .lsu_ready_ex_i    (lsu_ready_ex),
    .lsu_err_i         (lsu_err),
    .branch_in_ex_i    (branch_in_ex),
    .alu_dest_i        (alu_dest),
    .wb_dest_i         (wb_dest),
    .wb_ready_i        (wb_ready),
    .fw_wr_o           (fw_wr),
    .wb_wr_o           (wb_wr),
    .jump_target_o     (jump_target),
    .branch_decision_o (branch_decision),
    .mult_multicycle_o (mult_multicycle),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid)
  );

  // 10 ns clock
  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////
  // Reporting and compares
  //////////////////////////////

  task automatic abort_run(input string what);
    $display("%s", what);
    $display("Result: FAILED");
    $fatal(1, "Run stopped");
  endtask

  task automatic check_word(input string name, input logic [`EX_XLEN-1:0] got,
                            input logic [`EX_XLEN-1:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  task automatic check_wr(input string name, input ex_pkg::rf_wr_t got,
                          input ex_pkg::rf_wr_t exp);
    if (got !== exp) begin
      abort_run($sformatf("Mismatch %s: got 0x%h expected 0x%h", name, got, exp));
    end
  endtask

  //////////////////////////////
  // Reference models
  //////////////////////////////

  function automatic logic [`EX_XLEN-1:0] ref_alu(input ex_pkg::alu_op_e op,
                                                  input logic [`EX_XLEN-1:0] a,
                                                  input logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_ADD:  return a + b;
      ex_pkg::ALU_SUB:  return a - b;
      ex_pkg::ALU_AND:  return a & b;
      ex_pkg::ALU_OR:   return a | b;
      ex_pkg::ALU_XOR:  return a ^ b;
      ex_pkg::ALU_SLL:  return a << b[4:0];
      ex_pkg::ALU_SRL:  return a >> b[4:0];
      // Sign bits filled in above the word, then shifted down
      ex_pkg::ALU_SRA:  return 32'({{32{a[31]}}, a} >> b[4:0]);
      ex_pkg::ALU_SLT:  return ($signed(a) < $signed(b)) ? 1 : 0;
      ex_pkg::ALU_SLTU: return (a < b) ? 1 : 0;
      default:          return '0;
    endcase
  endfunction

  function automatic logic ref_cmp(input ex_pkg::alu_op_e op, input logic [`EX_XLEN-1:0] a,
                                   input logic [`EX_XLEN-1:0] b);
    case (op)
      ex_pkg::ALU_EQ:  return a == b;
      ex_pkg::ALU_NE:  return a != b;
      ex_pkg::ALU_LT:  return $signed(a) < $signed(b);
      ex_pkg::ALU_GE:  return $signed(a) >= $signed(b);
      ex_pkg::ALU_LTU: return a < b;
      ex_pkg::ALU_GEU: return a >= b;
      default:         return 1'b0;
    endcase
  endfunction

  // Lower word of the full unsigned 64 bit product
  function automatic logic [`EX_XLEN-1:0] ref_mul_low(input logic [`EX_XLEN-1:0] a,
                                                      input logic [`EX_XLEN-1:0] b);
    logic [63:0] full;
    full = {32'd0, a} * {32'd0, b};
    return full[31:0];
  endfunction

  // Upper word from a full 64 bit product of the extended operands
  function automatic logic [`EX_XLEN-1:0] ref_mul_high(input ex_pkg::mul_op_e op,
                                                       input logic [`EX_XLEN-1:0] a,
                                                       input logic [`EX_XLEN-1:0] b);
    logic [63:0] ext_a;
    logic [63:0] ext_b;
    logic [63:0] full;
    ext_a = {{32{a[31] & (op != ex_pkg::MUL_MULHU)}}, a};
    ext_b = {{32{b[31] & (op == ex_pkg::MUL_MULH)}}, b};
    full  = ext_a * ext_b;
    return full[63:32];
  endfunction

  //////////////////////////////
  // Stimulus helpers
  //////////////////////////////

  // Inputs change 1 ns after the rising edge
  task automatic advance;
    @(posedge clk);
    #1;
  endtask

  // Let combinational outputs follow the new inputs
  task automatic settle;
    #1;
  endtask

  task automatic clear_inputs;
    alu_cmd      = '0;
    mul_cmd      = '0;
    csr_access   = 1'b0;
    csr_rdata    = '0;
    lsu_en       = 1'b0;
    lsu_err      = 1'b0;
    branch_in_ex = 1'b0;
    alu_dest     = '0;
    wb_dest      = '0;
  endtask

  //////////////////////////////
  // Directed tests
  //////////////////////////////

  task automatic test_reset;
    advance;
    clear_inputs();
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    check_bit("fw_wr_o.we", fw_wr.we, 1'b0);
    check_bit("mult_multicycle_o", mult_multicycle, 1'b0);
  endtask

  task automatic test_alu;
    ex_pkg::rf_wr_t exp;
    for (int i = 0; i <= int'(ex_pkg::ALU_SLTU); i++) begin
      repeat (2) begin
        advance();
        alu_cmd.enable    = 1'b1;
        alu_cmd.op        = ex_pkg::alu_op_e'(i);
        alu_cmd.operand_a = $random(seed);
        alu_cmd.operand_b = $random(seed);
        alu_dest.we       = $random(seed);
        alu_dest.addr     = $random(seed);
        settle();
        exp.we   = alu_dest.we;
        exp.addr = alu_dest.addr;
        exp.data = ref_alu(alu_cmd.op, alu_cmd.operand_a, alu_cmd.operand_b);
        check_wr("fw_wr_o", fw_wr, exp);
      end
    end
    clear_inputs();
  endtask

  task automatic test_branch;
    for (int i = int'(ex_pkg::ALU_EQ); i <= int'(ex_pkg::ALU_GEU); i++) begin
      for (int k = 0; k < 2; k++) begin
        advance();
        alu_cmd.enable    = 1'b1;
        alu_cmd.op        = ex_pkg::alu_op_e'(i);
        alu_cmd.operand_a = $random(seed);
        // Second pass compares equal operands
        alu_cmd.operand_b = (k == 1) ? alu_cmd.operand_a : $random(seed);
        alu_cmd.operand_c = $random(seed);
        settle();
        check_bit("branch_decision_o", branch_decision,
                  ref_cmp(alu_cmd.op, alu_cmd.operand_a, alu_cmd.operand_b));
        check_word("jump_target_o", jump_target, alu_cmd.operand_c);
        check_word("fw_wr_o.data", fw_wr.data, '0);
      end
    end
    // Branch in EX releases the stage under back-pressure
    advance();
    wb_ready     = 1'b0;
    branch_in_ex = 1'b1;
    settle();
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_bit("ex_valid_o", ex_valid, 1'b0);
    advance();
    wb_ready = 1'b1;
    clear_inputs();
  endtask

  task automatic test_mult;
    int low_cycles;
    advance();
    mul_cmd.enable    = 1'b1;
    mul_cmd.op        = ex_pkg::MUL_MUL;
    mul_cmd.operand_a = $random(seed);
    mul_cmd.operand_b = $random(seed);
    alu_dest          = '{we: 1'b1, addr: 6'h11};
    settle();
    check_bit("ex_ready_o", ex_ready, 1'b1);
    check_word("fw_wr_o.data", fw_wr.data, ref_mul_low(mul_cmd.operand_a, mul_cmd.operand_b));
    for (int i = int'(ex_pkg::MUL_MULH); i <= int'(ex_pkg::MUL_MULHU); i++) begin
      advance();
      mul_cmd.op        = ex_pkg::mul_op_e'(i);
      mul_cmd.operand_a = $random(seed);
      mul_cmd.operand_b = $random(seed);
      settle();
      low_cycles = 0;
      while (!ex_ready) begin
        low_cycles++;
        if (low_cycles > 8) begin
          abort_run("High multiply never signalled ready");
        end
        advance();
        settle();
      end
      check_word("ex_ready_o low cycles", 32'(low_cycles), 32'd2);
      check_bit("mult_multicycle_o", mult_multicycle, 1'b1);
      check_word("fw_wr_o.data", fw_wr.data,
                 ref_mul_high(mul_cmd.op, mul_cmd.operand_a, mul_cmd.operand_b));
    end
    advance();
    clear_inputs();
  endtask

  task automatic test_priority;
    advance();
    alu_cmd.enable    = 1'b1;
    alu_cmd.op        = ex_pkg::ALU_ADD;
    alu_cmd.operand_a = $random(seed);
    alu_cmd.operand_b = $random(seed);
    mul_cmd.enable    = 1'b1;
    mul_cmd.op        = ex_pkg::MUL_MUL;
    mul_cmd.operand_a = $random(seed);
    mul_cmd.operand_b = $random(seed);
    csr_access        = 1'b1;
    csr_rdata         = $random(seed);
    settle();
    check_word("fw_wr_o.data", fw_wr.data, csr_rdata);
    advance();
    csr_access = 1'b0;
    settle();
    check_word("fw_wr_o.data", fw_wr.data, ref_mul_low(mul_cmd.operand_a, mul_cmd.operand_b));
    clear_inputs();
  endtask

  task automatic test_writeback;
    ex_pkg::rf_wr_t exp;
    // Accepted instruction reaches the writeback port
    advance();
    alu_cmd.enable = 1'b1;
    wb_dest        = '{we: 1'b1, addr: 6'h2a};
    settle();
    check_bit("ex_valid_o", ex_valid, 1'b1);
    advance();
    clear_inputs();
    lsu_rdata = $random(seed);
    settle();
    exp = '{we: 1'b1, addr: 6'h2a, data: lsu_rdata};
    check_wr("wb_wr_o", wb_wr, exp);
    // Drains with nothing behind it
    advance();
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    // Faulting load
    advance();
    lsu_en  = 1'b1;
    lsu_err = 1'b1;
    wb_dest = '{we: 1'b1, addr: 6'h15};
    settle();
    check_bit("ex_valid_o", ex_valid, 1'b1);
    advance();
    clear_inputs();
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
    // Hold under back-pressure
    advance();
    lsu_en  = 1'b1;
    wb_dest = '{we: 1'b1, addr: 6'h33};
    advance();
    wb_ready = 1'b0;
    wb_dest  = '{we: 1'b1, addr: 6'h07};
    settle();
    check_bit("ex_valid_o", ex_valid, 1'b0);
    check_word("wb_wr_o.addr", 32'(wb_wr.addr), 32'h33);
    advance();
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b1);
    check_word("wb_wr_o.addr", 32'(wb_wr.addr), 32'h33);
    advance();
    clear_inputs();
    wb_ready = 1'b1;
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b1);
    advance();
    settle();
    check_bit("wb_wr_o.we", wb_wr.we, 1'b0);
  endtask

  //////////////////////////////
  // Watchdog and main sequence
  //////////////////////////////

  initial begin
    #(TIMEOUT_NS);
    abort_run($sformatf("Timeout after %0d ns, the tests did not finish", TIMEOUT_NS));
  end

  initial begin
    seed         = 32'h2156;
    clk          = 1'b0;
    rst_n        = 1'b0;
    lsu_rdata    = '0;
    lsu_ready_ex = 1'b1;
    wb_ready     = 1'b1;
    clear_inputs();
    repeat (RESET_CYCLES) @(posedge clk);
    #1;
    rst_n = 1'b1;
    test_reset();
    test_alu();
    test_branch();
    test_mult();
    test_priority();
    test_writeback();
    advance();
    if (i_ex_stage_top.i_ex_stage_props.assert_fails == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      abort_run("One or more stage assertions failed during the run");
    end
  end

endmodule

//--- compile.f
+incdir+common
common/ex_pkg.sv
alu/ex_alu.sv
mult/ex_mult.sv
design/ex_issue_ctrl.sv
design/ex_write_ports.sv
design/ex_stage_top.sv
bench/ex_stage_props.sv
bench/ex_stage_tb.sv

//--- Bender.yml
package:
  name: ex_stage

export_include_dirs:
  - common

sources:
  - include_dirs:
      - common
    files:
      - common/ex_pkg.sv
      - alu/ex_alu.sv
      - mult/ex_mult.sv
      - design/ex_issue_ctrl.sv
      - design/ex_write_ports.sv
      - design/ex_stage_top.sv
  - target: simulation
    include_dirs:
      - common
    files:
      - bench/ex_stage_props.sv
      - bench/ex_stage_tb.sv
